//--- files.f
hdl/i3c_standby_pkg.sv
hdl/bus_owner_fsm.sv
hdl/bus_flow_mux.sv
hdl/bus_timers.sv
hdl/target_reset_ctrl.sv
hdl/i3c_standby_core.sv
tests/i3c_standby_core_sva.sv
tests/tb_i3c_standby_core.sv

//--- hdl/bus_flow_mux.sv
// Steers the owning agent's TX/RX requests to the bus engines and their replies back
`timescale 1ns/1ps
`default_nettype none

module bus_flow_mux (
  input  i3c_standby_pkg::owner_e owner_i,

  input  logic                    fsm_tx_req_byte_i,
  input  logic                    fsm_tx_req_bit_i,
  input  i3c_standby_pkg::byte_t  fsm_tx_value_i,
  input  logic                    fsm_tx_sel_od_pp_i,
  input  logic                    fsm_rx_req_bit_i,
  input  logic                    fsm_rx_req_byte_i,

  input  logic                    ccc_tx_req_byte_i,
  input  logic                    ccc_tx_req_bit_i,
  input  i3c_standby_pkg::byte_t  ccc_tx_value_i,
  input  logic                    ccc_tx_sel_od_pp_i,
  input  logic                    ccc_rx_req_bit_i,
  input  logic                    ccc_rx_req_byte_i,

  input  logic                    ibi_tx_req_byte_i,
  input  logic                    ibi_tx_req_bit_i,
  input  i3c_standby_pkg::byte_t  ibi_tx_value_i,
  input  logic                    ibi_tx_sel_od_pp_i,
  input  logic                    ibi_rx_req_bit_i,
  input  logic                    ibi_rx_req_byte_i,

  input  logic                    bus_tx_done_i,
  input  logic                    bus_tx_err_i,
  input  logic                    bus_rx_done_i,
  input  i3c_standby_pkg::byte_t  bus_rx_data_i,

  output logic                    bus_tx_req_byte_o,
  output logic                    bus_tx_req_bit_o,
  output i3c_standby_pkg::byte_t  bus_tx_value_o,
  output logic                    bus_tx_sel_od_pp_o,
  output logic                    bus_rx_req_bit_o,
  output logic                    bus_rx_req_byte_o,

  output logic                    fsm_tx_done_o,
  output logic                    fsm_tx_err_o,
  output logic                    fsm_rx_done_o,
  output i3c_standby_pkg::byte_t  fsm_rx_data_o,

  output logic                    ccc_tx_done_o,
  output logic                    ccc_tx_err_o,
  output logic                    ccc_rx_done_o,
  output i3c_standby_pkg::byte_t  ccc_rx_data_o,

  output logic                    ibi_tx_done_o,
  output logic                    ibi_rx_done_o,
  output i3c_standby_pkg::byte_t  ibi_rx_data_o
);

  always_comb begin
    bus_tx_req_byte_o  = 1'b0;
    bus_tx_req_bit_o   = 1'b0;
    bus_tx_value_o     = '0;
    bus_tx_sel_od_pp_o = 1'b0;
    bus_rx_req_bit_o   = 1'b0;
    bus_rx_req_byte_o  = 1'b0;
    fsm_tx_done_o      = 1'b0;
    fsm_tx_err_o       = 1'b0;
    fsm_rx_done_o      = 1'b0;
    fsm_rx_data_o      = '0;
    ccc_tx_done_o      = 1'b0;
    ccc_tx_err_o       = 1'b0;
    ccc_rx_done_o      = 1'b0;
    ccc_rx_data_o      = '0;
    ibi_tx_done_o      = 1'b0;
    ibi_rx_done_o      = 1'b0;
    ibi_rx_data_o      = '0;

    case (owner_i)
      i3c_standby_pkg::OwnerFsm: begin
        bus_tx_req_byte_o  = fsm_tx_req_byte_i;
        bus_tx_req_bit_o   = fsm_tx_req_bit_i;
        bus_tx_value_o     = fsm_tx_value_i;
        bus_tx_sel_od_pp_o = fsm_tx_sel_od_pp_i;
        bus_rx_req_bit_o   = fsm_rx_req_bit_i;
        bus_rx_req_byte_o  = fsm_rx_req_byte_i;
        fsm_tx_done_o      = bus_tx_done_i;
        fsm_tx_err_o       = bus_tx_err_i;
        fsm_rx_done_o      = bus_rx_done_i;
        fsm_rx_data_o      = bus_rx_data_i;
      end
      i3c_standby_pkg::OwnerCcc: begin
        bus_tx_req_byte_o  = ccc_tx_req_byte_i;
        bus_tx_req_bit_o   = ccc_tx_req_bit_i;
        bus_tx_value_o     = ccc_tx_value_i;
        bus_tx_sel_od_pp_o = ccc_tx_sel_od_pp_i;
        bus_rx_req_bit_o   = ccc_rx_req_bit_i;
        bus_rx_req_byte_o  = ccc_rx_req_byte_i;
        ccc_tx_done_o      = bus_tx_done_i;
        ccc_tx_err_o       = bus_tx_err_i;
        ccc_rx_done_o      = bus_rx_done_i;
        ccc_rx_data_o      = bus_rx_data_i;
      end
      i3c_standby_pkg::OwnerIbi: begin
        bus_tx_req_byte_o  = ibi_tx_req_byte_i;
        bus_tx_req_bit_o   = ibi_tx_req_bit_i;
        bus_tx_value_o     = ibi_tx_value_i;
        bus_tx_sel_od_pp_o = ibi_tx_sel_od_pp_i;
        bus_rx_req_bit_o   = ibi_rx_req_bit_i;
        bus_rx_req_byte_o  = ibi_rx_req_byte_i;
        // IBI engine has no TX error input
        ibi_tx_done_o      = bus_tx_done_i;
        ibi_rx_done_o      = bus_rx_done_i;
        ibi_rx_data_o      = bus_rx_data_i;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/bus_owner_fsm.sv
// Arbitrates ownership of the bus engines between target FSM, CCC handler and IBI engine
`timescale 1ns/1ps
`default_nettype none

module bus_owner_fsm (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   ccc_valid_i,
  input  logic                   ibi_begin_i,
  input  logic                   ccc_done_i,
  input  logic                   next_ccc_i,
  input  logic                   ibi_done_i,
  output i3c_standby_pkg::owner_e owner_o
);

  i3c_standby_pkg::owner_e owner_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      owner_q <= i3c_standby_pkg::OwnerFsm;
    end else begin
      case (owner_q)
        i3c_standby_pkg::OwnerFsm: begin
          // Simultaneous requests are ignored, target FSM keeps the bus
          if (ccc_valid_i && !ibi_begin_i) begin
            owner_q <= i3c_standby_pkg::OwnerCcc;
          end else if (ibi_begin_i && !ccc_valid_i) begin
            owner_q <= i3c_standby_pkg::OwnerIbi;
          end
        end
        i3c_standby_pkg::OwnerCcc: begin
          if (ccc_done_i || next_ccc_i) begin
            owner_q <= i3c_standby_pkg::OwnerFsm;
          end
        end
        i3c_standby_pkg::OwnerIbi: begin
          if (ibi_done_i) begin
            owner_q <= i3c_standby_pkg::OwnerFsm;
          end
        end
        default: owner_q <= i3c_standby_pkg::OwnerFsm;
      endcase
    end
  end

  assign owner_o = owner_q;

endmodule

`default_nettype wire

//--- hdl/bus_timers.sv
// Counts cycles since the last STOP and flags bus free, idle and available conditions
`timescale 1ns/1ps
`default_nettype none

module bus_timers (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    enable_i,
  input  logic                    stop_det_i,
  input  i3c_standby_pkg::timer_t t_bus_free_i,
  input  i3c_standby_pkg::timer_t t_bus_idle_i,
  input  i3c_standby_pkg::timer_t t_bus_available_i,
  output logic                    bus_free_o,
  output logic                    bus_idle_o,
  output logic                    bus_available_o
);

  i3c_standby_pkg::timer_t count_q;

  // Restart on every STOP, hold at zero while disabled
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (stop_det_i || !enable_i) begin
      count_q <= '0;
    end else if (count_q != i3c_standby_pkg::TimerMax) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign bus_free_o      = enable_i && (count_q >= t_bus_free_i);
  assign bus_idle_o      = enable_i && (count_q >= t_bus_idle_i);
  assign bus_available_o = enable_i && (count_q >= t_bus_available_i);

endmodule

`default_nettype wire

//--- hdl/i3c_standby_core.sv
// Top of the I3C standby glue layer, instantiated between the target agents and bus engines
`timescale 1ns/1ps
`default_nettype none

module i3c_standby_core (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         ccc_valid_i,
  input  logic                         ibi_begin_i,
  input  logic                         ccc_done_i,
  input  logic                         next_ccc_i,
  input  logic                         ibi_done_i,
  input  logic                         fsm_tx_req_byte_i,
  input  logic                         fsm_tx_req_bit_i,
  input  i3c_standby_pkg::byte_t       fsm_tx_value_i,
  input  logic                         fsm_tx_sel_od_pp_i,
  input  logic                         fsm_rx_req_bit_i,
  input  logic                         fsm_rx_req_byte_i,
  input  logic                         ccc_tx_req_byte_i,
  input  logic                         ccc_tx_req_bit_i,
  input  i3c_standby_pkg::byte_t       ccc_tx_value_i,
  input  logic                         ccc_tx_sel_od_pp_i,
  input  logic                         ccc_rx_req_bit_i,
  input  logic                         ccc_rx_req_byte_i,
  input  logic                         ibi_tx_req_byte_i,
  input  logic                         ibi_tx_req_bit_i,
  input  i3c_standby_pkg::byte_t       ibi_tx_value_i,
  input  logic                         ibi_tx_sel_od_pp_i,
  input  logic                         ibi_rx_req_bit_i,
  input  logic                         ibi_rx_req_byte_i,
  input  logic                         bus_tx_done_i,
  input  logic                         bus_tx_err_i,
  input  logic                         bus_rx_done_i,
  input  i3c_standby_pkg::byte_t       bus_rx_data_i,
  output logic                         bus_tx_req_byte_o,
  output logic                         bus_tx_req_bit_o,
  output i3c_standby_pkg::byte_t       bus_tx_value_o,
  output logic                         bus_tx_sel_od_pp_o,
  output logic                         bus_rx_req_bit_o,
  output logic                         bus_rx_req_byte_o,
  output logic                         fsm_tx_done_o,
  output logic                         fsm_tx_err_o,
  output logic                         fsm_rx_done_o,
  output i3c_standby_pkg::byte_t       fsm_rx_data_o,
  output logic                         ccc_tx_done_o,
  output logic                         ccc_tx_err_o,
  output logic                         ccc_rx_done_o,
  output i3c_standby_pkg::byte_t       ccc_rx_data_o,
  output logic                         ibi_tx_done_o,
  output logic                         ibi_rx_done_o,
  output i3c_standby_pkg::byte_t       ibi_rx_data_o,
  input  logic                         i3c_standby_en_i,
  input  logic                         stop_det_i,
  input  i3c_standby_pkg::timer_t      t_bus_free_i,
  input  i3c_standby_pkg::timer_t      t_bus_idle_i,
  input  i3c_standby_pkg::timer_t      t_bus_available_i,
  output logic                         bus_free_o,
  output logic                         bus_idle_o,
  output logic                         bus_available_o,
  input  logic                         rst_action_valid_i,
  input  i3c_standby_pkg::rst_action_t rst_action_i,
  input  logic                         target_reset_detect_i,
  input  logic                         escalate_reset_i,
  input  logic                         rstact_armed_i,
  input  logic                         peripheral_reset_done_i,
  output logic                         peripheral_reset_o,
  output logic                         escalated_reset_o,
  input  logic                         tx_sda_i,
  input  logic                         ibi_sda_i,
  output logic                         ctrl_sda_o
);

  i3c_standby_pkg::owner_e owner;

  bus_owner_fsm i_bus_owner_fsm (
    .clk_i,
    .rst_ni,
    .ccc_valid_i,
    .ibi_begin_i,
    .ccc_done_i,
    .next_ccc_i,
    .ibi_done_i,
    .owner_o (owner)
  );

  bus_flow_mux i_bus_flow_mux (
    .owner_i (owner),
    .fsm_tx_req_byte_i,
    .fsm_tx_req_bit_i,
    .fsm_tx_value_i,
    .fsm_tx_sel_od_pp_i,
    .fsm_rx_req_bit_i,
    .fsm_rx_req_byte_i,
    .ccc_tx_req_byte_i,
    .ccc_tx_req_bit_i,
    .ccc_tx_value_i,
    .ccc_tx_sel_od_pp_i,
    .ccc_rx_req_bit_i,
    .ccc_rx_req_byte_i,
    .ibi_tx_req_byte_i,
    .ibi_tx_req_bit_i,
    .ibi_tx_value_i,
    .ibi_tx_sel_od_pp_i,
    .ibi_rx_req_bit_i,
    .ibi_rx_req_byte_i,
    .bus_tx_done_i,
    .bus_tx_err_i,
    .bus_rx_done_i,
    .bus_rx_data_i,
    .bus_tx_req_byte_o,
    .bus_tx_req_bit_o,
    .bus_tx_value_o,
    .bus_tx_sel_od_pp_o,
    .bus_rx_req_bit_o,
    .bus_rx_req_byte_o,
    .fsm_tx_done_o,
    .fsm_tx_err_o,
    .fsm_rx_done_o,
    .fsm_rx_data_o,
    .ccc_tx_done_o,
    .ccc_tx_err_o,
    .ccc_rx_done_o,
    .ccc_rx_data_o,
    .ibi_tx_done_o,
    .ibi_rx_done_o,
    .ibi_rx_data_o
  );

  bus_timers i_bus_timers (
    .clk_i,
    .rst_ni,
    .enable_i          (i3c_standby_en_i),
    .stop_det_i,
    .t_bus_free_i,
    .t_bus_idle_i,
    .t_bus_available_i,
    .bus_free_o,
    .bus_idle_o,
    .bus_available_o
  );

  target_reset_ctrl i_target_reset_ctrl (
    .clk_i,
    .rst_ni,
    .rst_action_valid_i,
    .rst_action_i,
    .target_reset_detect_i,
    .escalate_reset_i,
    .rstact_armed_i,
    .peripheral_reset_done_i,
    .peripheral_reset_o,
    .escalated_reset_o
  );

  // Open-drain style, either driver may pull SDA low
  assign ctrl_sda_o = tx_sda_i & ibi_sda_i;

endmodule

`default_nettype wire

//--- hdl/i3c_standby_pkg.sv
// Shared widths, bus owner encoding and RSTACT codes, referenced by scoped name
`default_nettype none

package i3c_standby_pkg;

  // Data byte on the bus engines
  typedef logic [7:0] byte_t;

  // Time thresholds and the bus counter, in clock cycles
  typedef logic [19:0] timer_t;

  // Defining byte of the RSTACT command
  typedef logic [7:0] rst_action_t;

  // Agent currently driving the shared TX/RX engines
  typedef enum logic [1:0] {
    OwnerFsm = 2'd0,
    OwnerCcc = 2'd1,
    OwnerIbi = 2'd2
  } owner_e;

  // RSTACT codes handled locally
  localparam rst_action_t RstActPeriph   = 8'h01;
  localparam rst_action_t RstActEscalate = 8'h02;

  // Counter stops here instead of wrapping
  localparam timer_t TimerMax = '1;

endpackage

`default_nettype wire

//--- hdl/target_reset_ctrl.sv
// Turns RSTACT actions and target reset patterns into peripheral and escalated resets
`timescale 1ns/1ps
`default_nettype none

module target_reset_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         rst_action_valid_i,
  input  i3c_standby_pkg::rst_action_t rst_action_i,
  input  logic                         target_reset_detect_i,
  input  logic                         escalate_reset_i,
  input  logic                         rstact_armed_i,
  input  logic                         peripheral_reset_done_i,
  output logic                         peripheral_reset_o,
  output logic                         escalated_reset_o
);

  logic periph_req;
  logic escal_req;

  // First pattern resets the peripheral, the next one escalates
  assign periph_req =
      (rst_action_valid_i && (rst_action_i == i3c_standby_pkg::RstActPeriph)) ||
      (target_reset_detect_i && !escalate_reset_i && !rstact_armed_i);
  assign escal_req =
      (rst_action_valid_i && (rst_action_i == i3c_standby_pkg::RstActEscalate)) ||
      (target_reset_detect_i && escalate_reset_i && !rstact_armed_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      peripheral_reset_o <= 1'b0;
    end else if (peripheral_reset_done_i) begin
      peripheral_reset_o <= 1'b0;
    end else if (periph_req) begin
      peripheral_reset_o <= 1'b1;
    end
  end

  // Sticky until the block itself is reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      escalated_reset_o <= 1'b0;
    end else if (escal_req) begin
      escalated_reset_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the standby core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_i3c_standby_core -f files.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_i3c_standby_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\*\* TEST PASSED \*\*\*$' sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- tests/i3c_standby_core_sva.sv
// Concurrent checks on owner encoding and reset outputs, bound into the standby core
`timescale 1ns/1ps
`default_nettype none

module i3c_standby_core_sva (
  input logic                    clk_i,
  input logic                    rst_ni,
  input i3c_standby_pkg::owner_e owner_i,
  input logic                    peripheral_reset_done_i,
  input logic                    peripheral_reset_o,
  input logic                    escalated_reset_o
);

  owner_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    owner_i inside {i3c_standby_pkg::OwnerFsm, i3c_standby_pkg::OwnerCcc,
                    i3c_standby_pkg::OwnerIbi})
    else $error("Owner left the legal encodings");

  // Sticky until rst_ni
  escalated_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$fell(escalated_reset_o))
    else $error("Escalated reset dropped without rst_ni");

  periph_cleared: assert property (@(posedge clk_i) disable iff (!rst_ni)
    peripheral_reset_done_i |=> !peripheral_reset_o)
    else $error("Peripheral reset still high after done");

endmodule

bind i3c_standby_core i3c_standby_core_sva i_i3c_standby_core_sva (
  .clk_i                   (clk_i),
  .rst_ni                  (rst_ni),
  .owner_i                 (owner),
  .peripheral_reset_done_i (peripheral_reset_done_i),
  .peripheral_reset_o      (peripheral_reset_o),
  .escalated_reset_o       (escalated_reset_o)
);

`default_nettype wire

//--- tests/tb_i3c_standby_core.sv
// Table-driven testbench for the I3C standby core, run from files.f with the bound assertions
`timescale 1ns/1ps
`default_nettype none

module tb_i3c_standby_core;

  // One table row: stimulus for a cycle and the state expected during that cycle
  typedef struct packed {
    logic [4:0]              strobes;   // ccc_valid, ibi_begin, ccc_done, next_ccc, ibi_done
    logic [1:0]              tmr;       // enable, stop
    logic [5:0]              rst_ctl;   // rst, valid, detect, escalate, armed, done
    i3c_standby_pkg::rst_action_t act;
    logic [4:0]              fsm_req;   // tx byte, tx bit, od/pp, rx bit, rx byte
    i3c_standby_pkg::byte_t  fsm_val;
    logic [4:0]              ccc_req;
    i3c_standby_pkg::byte_t  ccc_val;
    logic [4:0]              ibi_req;
    i3c_standby_pkg::byte_t  ibi_val;
    logic [2:0]              replies;   // tx done, tx err, rx done
    i3c_standby_pkg::byte_t  rx_data;
    logic [1:0]              sda;
    i3c_standby_pkg::owner_e exp_owner;
    logic [2:0]              exp_flags; // free, idle, available
    logic [1:0]              exp_rst;   // peripheral, escalated
  } row_t;

  logic clk_i, rst_ni;
  logic ccc_valid_i, ibi_begin_i, ccc_done_i, next_ccc_i, ibi_done_i;
  logic fsm_tx_req_byte_i, fsm_tx_req_bit_i, fsm_tx_sel_od_pp_i;
  logic fsm_rx_req_bit_i, fsm_rx_req_byte_i;
  logic ccc_tx_req_byte_i, ccc_tx_req_bit_i, ccc_tx_sel_od_pp_i;
  logic ccc_rx_req_bit_i, ccc_rx_req_byte_i;
  logic ibi_tx_req_byte_i, ibi_tx_req_bit_i, ibi_tx_sel_od_pp_i;
  logic ibi_rx_req_bit_i, ibi_rx_req_byte_i;
  i3c_standby_pkg::byte_t fsm_tx_value_i, ccc_tx_value_i, ibi_tx_value_i;
  logic bus_tx_done_i, bus_tx_err_i, bus_rx_done_i;
  i3c_standby_pkg::byte_t bus_rx_data_i;
  logic bus_tx_req_byte_o, bus_tx_req_bit_o, bus_tx_sel_od_pp_o;
  logic bus_rx_req_bit_o, bus_rx_req_byte_o;
  i3c_standby_pkg::byte_t bus_tx_value_o;
  logic fsm_tx_done_o, fsm_tx_err_o, fsm_rx_done_o;
  logic ccc_tx_done_o, ccc_tx_err_o, ccc_rx_done_o;
  logic ibi_tx_done_o, ibi_rx_done_o;
  i3c_standby_pkg::byte_t fsm_rx_data_o, ccc_rx_data_o, ibi_rx_data_o;
  logic i3c_standby_en_i, stop_det_i;
  i3c_standby_pkg::timer_t t_bus_free_i, t_bus_idle_i, t_bus_available_i;
  logic bus_free_o, bus_idle_o, bus_available_o;
  logic rst_action_valid_i, target_reset_detect_i, escalate_reset_i;
  logic rstact_armed_i, peripheral_reset_done_i;
  i3c_standby_pkg::rst_action_t rst_action_i;
  logic peripheral_reset_o, escalated_reset_o;
  logic tx_sda_i, ibi_sda_i, ctrl_sda_o;

  row_t rows[$];
  int   cycle_count = 0;
  int   timeout_limit = 0;

  i3c_standby_core i_i3c_standby_core (.*);

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > timeout_limit) begin
      $display("Timeout after %0d cycles, the table did not finish", cycle_count);
      $display("*** TEST FAILED ***");
      $fatal(1, "Run stopped by timeout");
    end
  end

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s = %b, expected %b", $time, name, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic check_byte(input string name, input i3c_standby_pkg::byte_t got,
                            input i3c_standby_pkg::byte_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  task automatic check_timer(input string name, input i3c_standby_pkg::timer_t got,
                             input i3c_standby_pkg::timer_t exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s = %0d, expected %0d", $time, name, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Request fields and replies are random, SDA walks through all four pairs
  task automatic add_row(input logic [4:0] strobes, input logic [1:0] tmr,
                         input logic [5:0] rst_ctl, input i3c_standby_pkg::rst_action_t act,
                         input i3c_standby_pkg::owner_e own, input logic [2:0] flags,
                         input logic [1:0] rsts);
    row_t r;
    r.strobes   = strobes;
    r.tmr       = tmr;
    r.rst_ctl   = rst_ctl;
    r.act       = act;
    r.fsm_req   = 5'($urandom);
    r.fsm_val   = 8'($urandom);
    r.ccc_req   = 5'($urandom);
    r.ccc_val   = 8'($urandom);
    r.ibi_req   = 5'($urandom);
    r.ibi_val   = 8'($urandom);
    r.replies   = 3'($urandom);
    r.rx_data   = 8'($urandom);
    r.sda       = 2'(rows.size());
    r.exp_owner = own;
    r.exp_flags = flags;
    r.exp_rst   = rsts;
    rows.push_back(r);
  endtask

  task automatic build_table();
    // After reset the target FSM owns the engines
    add_row(5'b00000, 2'b11, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b00);
    add_row(5'b00000, 2'b11, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b00);
    // CCC handler ends once with ccc_done and once with next_ccc
    add_row(5'b10000, 2'b11, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b00);
    add_row(5'b00000, 2'b11, 6'b000000, 8'h00, i3c_standby_pkg::OwnerCcc, 3'b000, 2'b00);
    add_row(5'b01000, 2'b11, 6'b000000, 8'h00, i3c_standby_pkg::OwnerCcc, 3'b000, 2'b00);
    add_row(5'b00100, 2'b11, 6'b000000, 8'h00, i3c_standby_pkg::OwnerCcc, 3'b000, 2'b00);
    add_row(5'b00100, 2'b11, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b00);
    add_row(5'b10000, 2'b11, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b00);
    add_row(5'b00000, 2'b11, 6'b000000, 8'h00, i3c_standby_pkg::OwnerCcc, 3'b000, 2'b00);
    add_row(5'b00010, 2'b11, 6'b000000, 8'h00, i3c_standby_pkg::OwnerCcc, 3'b000, 2'b00);
    add_row(5'b00000, 2'b11, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b00);
    // IBI pass, then simultaneous requests
    add_row(5'b01000, 2'b11, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b00);
    add_row(5'b00000, 2'b11, 6'b000000, 8'h00, i3c_standby_pkg::OwnerIbi, 3'b000, 2'b00);
    add_row(5'b00110, 2'b11, 6'b000000, 8'h00, i3c_standby_pkg::OwnerIbi, 3'b000, 2'b00);
    add_row(5'b00001, 2'b11, 6'b000000, 8'h00, i3c_standby_pkg::OwnerIbi, 3'b000, 2'b00);
    add_row(5'b00000, 2'b11, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b00);
    add_row(5'b11000, 2'b11, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b00);
    add_row(5'b00001, 2'b11, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b00);
    // Peripheral reset by RSTACT and by pattern, done wins over a new request
    add_row(5'b00000, 2'b11, 6'b010000, i3c_standby_pkg::RstActPeriph,
            i3c_standby_pkg::OwnerFsm, 3'b000, 2'b00);
    add_row(5'b00000, 2'b11, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b10);
    add_row(5'b00000, 2'b11, 6'b000001, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b10);
    add_row(5'b00000, 2'b11, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b00);
    add_row(5'b00000, 2'b11, 6'b001000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b00);
    add_row(5'b00000, 2'b11, 6'b001001, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b10);
    add_row(5'b00000, 2'b11, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b00);
    // Armed patterns are ignored
    add_row(5'b00000, 2'b11, 6'b001010, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b00);
    add_row(5'b00000, 2'b11, 6'b001110, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b00);
    add_row(5'b00000, 2'b11, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b00);
    // Escalated reset by pattern, cleared only by rst_ni
    add_row(5'b00000, 2'b11, 6'b001100, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b00);
    add_row(5'b00000, 2'b11, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b01);
    add_row(5'b00000, 2'b11, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b01);
    add_row(5'b00000, 2'b11, 6'b100000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b00);
    add_row(5'b00000, 2'b11, 6'b010000, i3c_standby_pkg::RstActEscalate,
            i3c_standby_pkg::OwnerFsm, 3'b000, 2'b00);
    add_row(5'b00000, 2'b11, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b01);
    add_row(5'b00000, 2'b11, 6'b010000, 8'h03, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b01);
    add_row(5'b00000, 2'b11, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b01);
    // Thresholds 2, 4 and 6 cycles after the last STOP
    add_row(5'b00000, 2'b10, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b01);
    add_row(5'b00000, 2'b10, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b01);
    add_row(5'b00000, 2'b10, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b100, 2'b01);
    add_row(5'b00000, 2'b10, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b100, 2'b01);
    add_row(5'b00000, 2'b10, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b110, 2'b01);
    add_row(5'b00000, 2'b10, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b110, 2'b01);
    add_row(5'b00000, 2'b10, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b111, 2'b01);
    add_row(5'b00000, 2'b11, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b111, 2'b01);
    add_row(5'b00000, 2'b10, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b01);
    add_row(5'b00000, 2'b10, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b01);
    add_row(5'b00000, 2'b10, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b100, 2'b01);
    add_row(5'b00000, 2'b10, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b100, 2'b01);
    add_row(5'b00000, 2'b00, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b01);
    add_row(5'b00000, 2'b10, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b01);
    add_row(5'b00000, 2'b10, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b000, 2'b01);
    add_row(5'b00000, 2'b10, 6'b000000, 8'h00, i3c_standby_pkg::OwnerFsm, 3'b100, 2'b01);
  endtask

  task automatic apply_row(input row_t r);
    {ccc_valid_i, ibi_begin_i, ccc_done_i, next_ccc_i, ibi_done_i} = r.strobes;
    {i3c_standby_en_i, stop_det_i} = r.tmr;
    rst_ni = !r.rst_ctl[5];
    {rst_action_valid_i, target_reset_detect_i, escalate_reset_i} = r.rst_ctl[4:2];
    {rstact_armed_i, peripheral_reset_done_i} = r.rst_ctl[1:0];
    rst_action_i = r.act;
    {fsm_tx_req_byte_i, fsm_tx_req_bit_i, fsm_tx_sel_od_pp_i} = r.fsm_req[4:2];
    {fsm_rx_req_bit_i, fsm_rx_req_byte_i} = r.fsm_req[1:0];
    {ccc_tx_req_byte_i, ccc_tx_req_bit_i, ccc_tx_sel_od_pp_i} = r.ccc_req[4:2];
    {ccc_rx_req_bit_i, ccc_rx_req_byte_i} = r.ccc_req[1:0];
    {ibi_tx_req_byte_i, ibi_tx_req_bit_i, ibi_tx_sel_od_pp_i} = r.ibi_req[4:2];
    {ibi_rx_req_bit_i, ibi_rx_req_byte_i} = r.ibi_req[1:0];
    fsm_tx_value_i = r.fsm_val;
    ccc_tx_value_i = r.ccc_val;
    ibi_tx_value_i = r.ibi_val;
    {bus_tx_done_i, bus_tx_err_i, bus_rx_done_i} = r.replies;
    bus_rx_data_i = r.rx_data;
    {tx_sda_i, ibi_sda_i} = r.sda;
  endtask

  task automatic check_row(input row_t r, input i3c_standby_pkg::timer_t exp_count);
    logic [4:0] req;
    i3c_standby_pkg::byte_t val;
    logic own_fsm;
    logic own_ccc;
    logic own_ibi;
    own_fsm = (r.exp_owner == i3c_standby_pkg::OwnerFsm);
    own_ccc = (r.exp_owner == i3c_standby_pkg::OwnerCcc);
    own_ibi = (r.exp_owner == i3c_standby_pkg::OwnerIbi);
    req = own_ccc ? r.ccc_req : (own_ibi ? r.ibi_req : r.fsm_req);
    val = own_ccc ? r.ccc_val : (own_ibi ? r.ibi_val : r.fsm_val);
    check_bit("bus_tx_req_byte_o", bus_tx_req_byte_o, req[4]);
    check_bit("bus_tx_req_bit_o", bus_tx_req_bit_o, req[3]);
    check_bit("bus_tx_sel_od_pp_o", bus_tx_sel_od_pp_o, req[2]);
    check_bit("bus_rx_req_bit_o", bus_rx_req_bit_o, req[1]);
    check_bit("bus_rx_req_byte_o", bus_rx_req_byte_o, req[0]);
    check_byte("bus_tx_value_o", bus_tx_value_o, val);
    check_bit("fsm_tx_done_o", fsm_tx_done_o, own_fsm & r.replies[2]);
    check_bit("fsm_tx_err_o", fsm_tx_err_o, own_fsm & r.replies[1]);
    check_bit("fsm_rx_done_o", fsm_rx_done_o, own_fsm & r.replies[0]);
    check_byte("fsm_rx_data_o", fsm_rx_data_o, own_fsm ? r.rx_data : 8'h00);
    check_bit("ccc_tx_done_o", ccc_tx_done_o, own_ccc & r.replies[2]);
    check_bit("ccc_tx_err_o", ccc_tx_err_o, own_ccc & r.replies[1]);
    check_bit("ccc_rx_done_o", ccc_rx_done_o, own_ccc & r.replies[0]);
    check_byte("ccc_rx_data_o", ccc_rx_data_o, own_ccc ? r.rx_data : 8'h00);
    check_bit("ibi_tx_done_o", ibi_tx_done_o, own_ibi & r.replies[2]);
    check_bit("ibi_rx_done_o", ibi_rx_done_o, own_ibi & r.replies[0]);
    check_byte("ibi_rx_data_o", ibi_rx_data_o, own_ibi ? r.rx_data : 8'h00);
    check_timer("bus counter", i_i3c_standby_core.i_bus_timers.count_q, exp_count);
    check_bit("bus_free_o", bus_free_o, r.exp_flags[2]);
    check_bit("bus_idle_o", bus_idle_o, r.exp_flags[1]);
    check_bit("bus_available_o", bus_available_o, r.exp_flags[0]);
    check_bit("peripheral_reset_o", peripheral_reset_o, r.exp_rst[1]);
    check_bit("escalated_reset_o", escalated_reset_o, r.exp_rst[0]);
    check_bit("ctrl_sda_o", ctrl_sda_o, r.sda[1] & r.sda[0]);
  endtask

  initial begin
    i3c_standby_pkg::timer_t exp_count;
    void'($urandom(55215));
    clk_i = 1'b0;
    rst_ni = 1'b0;
    apply_row('0);
    rst_ni = 1'b0;
    t_bus_free_i = 20'd2;
    t_bus_idle_i = 20'd4;
    t_bus_available_i = 20'd6;
    build_table();
    timeout_limit = 2 * rows.size() + 8;
    exp_count = '0;
    repeat (8) @(posedge clk_i);
    for (int i = 0; i < rows.size(); i++) begin
      #1;
      apply_row(rows[i]);
      if (rows[i].rst_ctl[5]) begin
        exp_count = '0;
      end
      #97;
      check_row(rows[i], exp_count);
      // Counter model: clear on STOP, disable or reset, else count up to saturation
      if (rows[i].rst_ctl[5] || !rows[i].tmr[1] || rows[i].tmr[0]) begin
        exp_count = '0;
      end else if (exp_count != i3c_standby_pkg::TimerMax) begin
        exp_count = exp_count + 20'd1;
      end
      @(posedge clk_i);
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire
